//--- build.f
+incdir+hw
hw/apb_pkg.sv
hw/uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/sync_fifo.sv
hw/uart_apb_regs.sv
hw/uart_top.sv
dv/tb_clk_gen.sv
dv/uart_props.sv
dv/uart_tb.sv

//--- dv/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release lands just after an edge, like every other testbench input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

//--- dv/uart_props.sv
module uart_props (
  input logic              clk,
  input logic              rst_n,
  input apb_pkg::apb_req_t apb_req,
  input apb_pkg::apb_rsp_t apb_rsp,
  input logic              tx_busy,
  input logic              tx_start,
  input logic              tx_serial,
  input logic              rx_valid
);

  // Line idles high between frames
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx_serial)
    else $error("tx_serial is low while the transmitter is idle");

  // Master holds the request while the slave stretches the access phase
  apb_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
    else $error("APB request changed before pready");

  // A start pulse finds the transmitter idle and makes it busy next cycle
  tx_start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy ##1 tx_busy)
    else $error("tx_start issued while busy or tx_busy did not rise after it");

  rx_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid)
    else $error("rx_valid high on two cycles in a row");

endmodule

bind uart_top uart_props i_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .apb_req   (apb_req),
  .apb_rsp   (apb_rsp),
  .tx_busy   (tx_busy),
  .tx_start  (tx_start),
  .tx_serial (tx_serial),
  .rx_valid  (rx_valid)
);

//--- dv/uart_tb.sv
`include "uart_defines.svh"

module uart_tb;
  import apb_pkg::*;
  import uart_pkg::*;

  localparam int CLKS         = `UART_CLKS_PER_BIT;
  localparam int DEPTH        = `UART_RX_FIFO_DEPTH;
  localparam int APB_TIMEOUT  = 400;        // Longer than one frame of back-pressure
  localparam int LINE_TIMEOUT = 20 * CLKS;
  localparam int POLL_LIMIT   = 300;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     rx_serial;
  logic     tx_serial;
  integer   seed = 47;
  int       error_cnt = 0;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  uart_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .rx_serial (rx_serial),
    .tx_serial (tx_serial)
  );

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    error_cnt++;
    abort_run();
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      error_cnt++;
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input uart_status_t exp,
                              input uart_status_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      error_cnt++;
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
      error_cnt++;
      abort_run();
    end
  endtask

  task automatic wait_bit();
    repeat (CLKS) @(posedge clk);
    #2;
  endtask

  // One APB transfer with its response sampled at the falling edge
  task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int cycles;
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      cycles++;
      if (cycles > APB_TIMEOUT) report_timeout("APB transfer never saw pready");
      @(negedge clk);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_xfer(1'b1, addr, wdata, rdata, slverr);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                          output logic slverr);
    apb_xfer(1'b0, addr, 32'h0, rdata, slverr);
  endtask

  task automatic read_status(output uart_status_t st);
    logic [31:0] rdata;
    logic        slverr;
    apb_read(`UART_ADDR_STATUS, rdata, slverr);
    st = uart_status_t'(rdata);
  endtask

  task automatic read_data(output logic [7:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_read(`UART_ADDR_DATA, rdata, slverr);
    data = rdata[7:0];
  endtask

  task automatic wait_status(input uart_status_t mask, input uart_status_t want,
                             input string what);
    uart_status_t st;
    int           polls;
    polls = 0;
    read_status(st);
    while ((st & mask) != want) begin
      polls++;
      if (polls > POLL_LIMIT) report_timeout(what);
      read_status(st);
    end
  endtask

  // Start bit, eight data bits LSB first, stop bit, one idle bit time
  task automatic send_frame(input logic [7:0] data, input logic stop_level);
    @(posedge clk);
    #2;
    rx_serial = 1'b0;
    wait_bit();
    for (int i = 0; i < 8; i++) begin
      rx_serial = data[i];
      wait_bit();
    end
    rx_serial = stop_level;
    wait_bit();
    rx_serial = 1'b1;
    wait_bit();
  endtask

  task automatic recv_frame(output logic [7:0] data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (tx_serial) begin
      cycles++;
      if (cycles > LINE_TIMEOUT) report_timeout("no start bit on tx_serial");
      @(negedge clk);
    end
    repeat (CLKS / 2 - 1) @(negedge clk);  // Middle of the start bit
    check_bit("tx_serial start bit", 1'b0, tx_serial);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS) @(negedge clk);
      data[i] = tx_serial;
    end
    repeat (CLKS) @(negedge clk);
    check_bit("tx_serial stop bit", 1'b1, tx_serial);
  endtask

  function automatic logic [7:0] next_byte();
    int rnd;
    rnd = $random(seed);
    return rnd[7:0];
  endfunction

  task automatic test_receive();
    uart_status_t exp;
    uart_status_t st;
    logic [7:0]   b;
    logic [7:0]   got;
    for (int n = 0; n < 8; n++) begin
      b = next_byte();
      send_frame(b, 1'b1);
      exp = '0;
      exp.rx_not_empty = 1'b1;
      wait_status(exp, exp, "received byte never showed in STATUS");
      read_status(st);
      check_status("status after receive", exp, st);
      read_data(got);
      check_byte("rx data", b, got);
      read_status(st);
      check_status("status after data read", '0, st);
    end
  endtask

  task automatic test_transmit();
    uart_status_t exp;
    uart_status_t st;
    logic [7:0]   b;
    logic [7:0]   got;
    b = next_byte();
    apb_write(`UART_ADDR_DATA, {24'h0, b});
    fork
      recv_frame(got);
      begin
        repeat (3 * CLKS) @(posedge clk);
        read_status(st);
      end
    join
    exp = '0;
    exp.tx_busy = 1'b1;
    check_status("status during transmit", exp, st);
    check_byte("tx_serial byte", b, got);
    exp = '0;
    exp.tx_busy = 1'b1;
    wait_status(exp, '0, "tx_busy never fell after the frame");
    read_status(st);
    check_status("status after transmit", '0, st);
  endtask

  task automatic test_back_pressure();
    uart_status_t mask;
    logic [7:0]   b0;
    logic [7:0]   b1;
    logic [7:0]   r0;
    logic [7:0]   r1;
    time          t_wr2;
    time          t_rx0;
    b0 = next_byte();
    b1 = next_byte();
    fork
      begin
        apb_write(`UART_ADDR_DATA, {24'h0, b0});
        apb_write(`UART_ADDR_DATA, {24'h0, b1});
        t_wr2 = $time;
      end
      begin
        recv_frame(r0);
        t_rx0 = $time;
        recv_frame(r1);
      end
    join
    if (t_wr2 <= t_rx0) begin
      $display("Second DATA write completed at %0t, before the first frame ended", t_wr2);
      error_cnt++;
      abort_run();
    end
    check_byte("first tx byte", b0, r0);
    check_byte("second tx byte", b1, r1);
    mask = '0;
    mask.tx_busy = 1'b1;
    wait_status(mask, '0, "tx_busy never fell after back-to-back frames");
  endtask

  task automatic test_overrun();
    uart_status_t exp;
    uart_status_t st;
    logic [7:0]   sent [DEPTH + 2];
    logic [7:0]   got;
    for (int n = 0; n < DEPTH + 2; n++) begin
      sent[n] = next_byte();
      send_frame(sent[n], 1'b1);
    end
    exp = '0;
    exp.rx_overrun = 1'b1;
    wait_status(exp, exp, "rx_overrun never set");
    exp.rx_not_empty = 1'b1;
    read_status(st);
    check_status("status after overrun", exp, st);
    for (int n = 0; n < DEPTH; n++) begin
      read_data(got);
      check_byte("rx data after overrun", sent[n], got);
    end
    exp.rx_not_empty = 1'b0;
    read_status(st);
    check_status("status after draining", exp, st);
    apb_write(`UART_ADDR_STATUS, 32'h4);  // Clear the overrun flag
    read_status(st);
    check_status("status after overrun clear", '0, st);
  endtask

  task automatic test_framing_glitch();
    uart_status_t exp;
    uart_status_t st;
    logic [7:0]   b;
    logic [7:0]   got;
    send_frame(next_byte(), 1'b0);  // Stop bit held low
    exp = '0;
    exp.frame_err = 1'b1;
    wait_status(exp, exp, "frame_err never set");
    read_status(st);
    check_status("status after bad stop bit", exp, st);
    @(posedge clk);
    #2;
    rx_serial = 1'b0;
    repeat (CLKS / 2 - 3) @(posedge clk);
    #2;
    rx_serial = 1'b1;
    repeat (11) wait_bit();  // A glitch taken as a start bit would have queued by now
    read_status(st);
    check_status("status after glitch", exp, st);
    apb_write(`UART_ADDR_STATUS, 32'h8);
    b = next_byte();
    send_frame(b, 1'b1);
    exp = '0;
    exp.rx_not_empty = 1'b1;
    wait_status(exp, exp, "good frame after glitch never queued");
    read_status(st);
    check_status("status after good frame", exp, st);
    read_data(got);
    check_byte("rx data after glitch", b, got);
  endtask

  task automatic test_address_error();
    logic [31:0] rdata;
    logic        slverr;
    apb_read(4'h8, rdata, slverr);
    check_bit("pslverr on unmapped read", 1'b1, slverr);
    apb_read(`UART_ADDR_STATUS, rdata, slverr);
    check_bit("pslverr on STATUS read", 1'b0, slverr);
  endtask

  initial begin
    int cycles;
    apb_req   = '0;
    rx_serial = 1'b1;
    cycles    = 0;
    @(posedge clk);
    while (!rst_n) begin
      cycles++;
      if (cycles > 100) report_timeout("reset never released");
      @(posedge clk);
    end
    test_receive();
    test_transmit();
    test_back_pressure();
    test_overrun();
    test_framing_glitch();
    test_address_error();
    if (error_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

//--- hw/apb_pkg.sv
package apb_pkg;

  // Master to slave signals of one APB port
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;   // Byte offset inside the UART window
    logic [31:0] pwdata;
  } apb_req_t;

  // Slave to master signals
  typedef struct packed {
    logic        pready;   // Low stretches the access phase
    logic [31:0] prdata;
    logic        pslverr;  // Unmapped offset
  } apb_rsp_t;

endpackage

//--- hw/sync_fifo.sv
module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     wr_data,
  input  logic pop,
  output T     rd_data,
  output logic not_empty,
  output logic overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  T               mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full      = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  assign do_push   = push && (!full || do_pop);  // A pop frees the slot in the same cycle
  assign rd_data   = mem[rd_ptr];                // Head is always visible

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= push && !do_push;
      if (do_push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hw/uart_apb_regs.sv
`include "uart_defines.svh"

module uart_apb_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  input  logic [7:0]        rx_data,
  input  logic              rx_not_empty,
  output logic              rx_pop,
  input  logic              rx_overflow,
  input  logic              frame_err_pulse,
  input  logic              tx_busy,
  output logic              tx_start,
  output logic [7:0]        tx_byte
);
  import uart_pkg::*;

  logic         access;     // Access phase of a transfer
  logic         is_data;
  logic         is_status;
  logic         data_wr;
  logic         tx_stall;
  logic         status_wr;
  logic         overrun_q;
  logic         frame_err_q;
  uart_status_t status;
  uart_status_t wr_status;  // Write data seen as clear mask

  assign access    = apb_req.psel && apb_req.penable;
  assign is_data   = (apb_req.paddr == `UART_ADDR_DATA);
  assign is_status = (apb_req.paddr == `UART_ADDR_STATUS);
  assign data_wr   = access && apb_req.pwrite && is_data;
  assign status_wr = access && apb_req.pwrite && is_status;
  assign tx_stall  = data_wr && tx_busy;  // Back-pressure until the frame ends
  assign wr_status = uart_status_t'(apb_req.pwdata);

  assign tx_start = data_wr && !tx_busy;
  assign tx_byte  = apb_req.pwdata[7:0];
  assign rx_pop   = access && !apb_req.pwrite && is_data && rx_not_empty;

  always_comb begin
    status              = '0;
    status.rx_not_empty = rx_not_empty;
    status.tx_busy      = tx_busy;
    status.rx_overrun   = overrun_q;
    status.frame_err    = frame_err_q;
  end

  // Sticky flags, a new event wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (rx_overflow) begin
        overrun_q <= 1'b1;
      end else if (status_wr && wr_status.rx_overrun) begin
        overrun_q <= 1'b0;
      end

      if (frame_err_pulse) begin
        frame_err_q <= 1'b1;
      end else if (status_wr && wr_status.frame_err) begin
        frame_err_q <= 1'b0;
      end
    end
  end

  // Response is combinational, reads finish in the first access cycle
  always_comb begin
    apb_rsp         = '0;
    apb_rsp.pready  = !tx_stall;
    if (access) begin
      apb_rsp.pslverr = !(is_data || is_status);
      if (!apb_req.pwrite && is_data) begin
        apb_rsp.prdata = rx_not_empty ? {24'h0, rx_data} : 32'h0;  // Empty reads as zero
      end else if (!apb_req.pwrite && is_status) begin
        apb_rsp.prdata = status;
      end
    end
  end

endmodule

//--- hw/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Serial bit time in clock cycles
`define UART_CLKS_PER_BIT 16

// Receive FIFO entries
`define UART_RX_FIFO_DEPTH 4

// Register byte offsets on the APB side
`define UART_ADDR_DATA   4'h0
`define UART_ADDR_STATUS 4'h4

`endif

//--- hw/uart_pkg.sv
package uart_pkg;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start_bit,
    rx_data_bits,
    rx_stop_bit
  } uart_rx_state_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start_bit,
    tx_data_bits,
    tx_stop_bit
  } uart_tx_state_t;

  // One received frame as reported by the receiver
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;  // Stop bit read low
  } uart_rx_result_t;

  // STATUS register, bit 0 is rx_not_empty
  typedef struct packed {
    logic [27:0] rsvd;
    logic        frame_err;     // Bit 3, sticky
    logic        rx_overrun;    // Bit 2, sticky
    logic        tx_busy;       // Bit 1
    logic        rx_not_empty;  // Bit 0
  } uart_status_t;

endpackage

//--- hw/uart_rx.sv
`include "uart_defines.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx_serial,
  output uart_pkg::uart_rx_result_t rx_result,
  output logic                      rx_valid
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

  logic             rx_meta;     // First synchronizer stage
  logic             rx_sync;     // Line as seen by the FSM
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_data;
  logic             bit_end;     // Middle of a data or stop bit
  uart_rx_state_t   state;

  assign bit_end = (clk_cnt == LAST_CNT);

  // Idle line is high, so the synchronizer resets to one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync) state <= rx_start_bit;  // Falling edge of start bit
        end

        rx_start_bit: begin
          if (clk_cnt == HALF_CNT) begin
            clk_cnt <= '0;
            // A line back high at mid-bit was only a glitch
            state   <= rx_sync ? rx_idle : rx_data_bits;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        rx_data_bits: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= rx_stop_bit;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        rx_stop_bit: begin
          if (bit_end) begin
            clk_cnt  <= '0;
            rx_valid <= 1'b1;  // Reported good or bad, top decides
            state    <= rx_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        default: state <= rx_idle;
      endcase
    end
  end

  // Payload path, LSB arrives first and is shifted down
  always_ff @(posedge clk) begin
    if (state == rx_data_bits && bit_end) begin
      shift_data <= {rx_sync, shift_data[7:1]};
    end
    if (state == rx_stop_bit && bit_end) begin
      rx_result.data      <= shift_data;
      rx_result.frame_err <= !rx_sync;
    end
  end

endmodule

//--- hw/uart_top.sv
`include "uart_defines.svh"

module uart_top (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  input  logic              rx_serial,
  output logic              tx_serial
);
  import uart_pkg::*;

  uart_rx_result_t rx_result;
  uart_rx_result_t fifo_head;
  logic            rx_valid;
  logic            rx_push;
  logic            frame_err_pulse;
  logic            rx_not_empty;
  logic            rx_pop;
  logic            rx_overflow;
  logic            tx_busy;
  logic            tx_start;
  logic [7:0]      tx_byte;

  // Bad frames are flagged but never queued
  assign rx_push         = rx_valid && !rx_result.frame_err;
  assign frame_err_pulse = rx_valid && rx_result.frame_err;

  uart_apb_regs i_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .rx_data         (fifo_head.data),
    .rx_not_empty    (rx_not_empty),
    .rx_pop          (rx_pop),
    .rx_overflow     (rx_overflow),
    .frame_err_pulse (frame_err_pulse),
    .tx_busy         (tx_busy),
    .tx_start        (tx_start),
    .tx_byte         (tx_byte)
  );

  uart_rx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) i_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_serial (rx_serial),
    .rx_result (rx_result),
    .rx_valid  (rx_valid)
  );

  sync_fifo #(.T(uart_rx_result_t), .DEPTH(`UART_RX_FIFO_DEPTH)) i_rx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rx_push),
    .wr_data   (rx_result),
    .pop       (rx_pop),
    .rd_data   (fifo_head),
    .not_empty (rx_not_empty),
    .overflow  (rx_overflow)
  );

  uart_tx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) i_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .tx_serial (tx_serial)
  );

endmodule

//--- hw/uart_tx.sv
`include "uart_defines.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx_serial
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_data;  // Next data bit sits in bit 0
  logic             bit_end;
  uart_tx_state_t   state;

  assign bit_end = (clk_cnt == LAST_CNT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= tx_idle;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      shift_data <= '1;
      tx_busy    <= 1'b0;
      tx_serial  <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (tx_start) begin
            shift_data <= tx_byte;
            tx_serial  <= 1'b0;  // Start bit
            tx_busy    <= 1'b1;
            state      <= tx_start_bit;
          end
        end

        tx_start_bit, tx_data_bits: begin
          if (bit_end) begin
            clk_cnt <= '0;
            if (state == tx_data_bits && bit_idx == 3'd7) begin
              tx_serial <= 1'b1;  // Stop bit
              state     <= tx_stop_bit;
            end else begin
              tx_serial  <= shift_data[0];
              shift_data <= {1'b1, shift_data[7:1]};
              if (state == tx_data_bits) bit_idx <= bit_idx + 1'b1;
              state <= tx_data_bits;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        tx_stop_bit: begin
          if (bit_end) begin
            clk_cnt <= '0;
            tx_busy <= 1'b0;
            state   <= tx_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        default: state <= tx_idle;
      endcase
    end
  end

endmodule
